// ==== hw/access_classifier.sv ====
`include "l1d_defs.svh"

module access_classifier
    import l1d_geometry_pkg::*, mem_op_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic req_valid,
    input mem_op_t req_op,
    input logic req_load,
    input paddr_t req_paddr,
    input line_data_t req_store_value,
    input word_mask_t req_word_mask,
    input logic tlb_hit,
    input logic tlb_present,
    input logic tlb_supervisor,
    input logic tlb_writable,
    input logic supervisor_en,

    l1d_access_if.classifier access,

    output logic io_read_en,
    output logic io_write_en,
    output scalar_t io_addr,
    output scalar_t io_write_value,
    output logic resp_valid,
    output logic resp_trap,
    output trap_cause_t resp_trap_cause
);
    logic addr_in_io_region;
    logic tlb_miss;
    logic page_fault;
    logic supervisor_fault;
    logic alignment_fault;
    logic write_fault;
    logic any_fault;
    logic side_effect_ok;
    trap_cause_t trap_cause;

    assign addr_in_io_region = req_paddr[`L1D_ADDR_WIDTH - 1 -: 16] == `L1D_IO_PREFIX;

    // Permission bits mean nothing without a TLB hit, so the priority
    // chain below checks the miss first
    assign tlb_miss = req_valid && !tlb_hit;
    assign page_fault = req_valid && !tlb_present;
    assign supervisor_fault = req_valid && tlb_supervisor && !supervisor_en;
    assign alignment_fault = req_valid && op_misaligned(req_op, addr_offset(req_paddr));
    assign write_fault = req_valid && !req_load && !tlb_writable;
    assign any_fault = page_fault || supervisor_fault || alignment_fault || write_fault;

    // Nothing leaves this stage for a request that traps
    assign side_effect_ok = req_valid && tlb_hit && !any_fault;

    assign access.paddr = req_paddr;
    assign access.op = req_op;
    assign access.store_value = req_store_value;
    assign access.word_mask = req_word_mask;
    assign access.cached_load_en = side_effect_ok && !addr_in_io_region && req_load;
    assign access.cached_store_en = side_effect_ok && !addr_in_io_region && !req_load;
    assign access.lookup_en = req_valid && tlb_hit && !addr_in_io_region && req_load;

    assign io_read_en = side_effect_ok && addr_in_io_region && req_load;
    assign io_write_en = side_effect_ok && addr_in_io_region && !req_load;
    assign io_addr = {16'd0, req_paddr[15:0]};
    assign io_write_value = req_store_value[31:0];

    always_comb
    begin
        if (tlb_miss)
            trap_cause = TRAP_TLB_MISS;
        else if (page_fault)
            trap_cause = TRAP_PAGE_FAULT;
        else if (supervisor_fault)
            trap_cause = TRAP_SUPERVISOR;
        else if (alignment_fault)
            trap_cause = TRAP_UNALIGNED;
        else if (write_fault)
            trap_cause = TRAP_ILLEGAL_STORE;
        else
            trap_cause = TRAP_NONE;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            resp_valid <= 1'b0;
            resp_trap <= 1'b0;
            resp_trap_cause <= TRAP_NONE;
        end
        else
        begin
            resp_valid <= req_valid;
            resp_trap <= tlb_miss || any_fault;
            resp_trap_cause <= trap_cause;
        end
    end
endmodule

// ==== hw/dcache_data_stage.sv ====
`include "l1d_defs.svh"

module dcache_data_stage
    import l1d_geometry_pkg::*, mem_op_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic req_valid,
    input mem_op_t req_op,
    input logic req_load,
    input paddr_t req_paddr,
    input line_data_t req_store_value,
    input word_mask_t req_word_mask,
    input logic tlb_hit,
    input logic tlb_present,
    input logic tlb_supervisor,
    input logic tlb_writable,
    input logic supervisor_en,

    input logic fill_en,
    input l1d_way_idx_t fill_way,
    input l1d_set_idx_t fill_set,
    input l1d_tag_t fill_tag,
    input line_data_t fill_data,

    output logic store_en,
    output line_index_t store_line_addr,
    output byte_mask_t store_mask,
    output line_data_t store_data,

    output logic io_read_en,
    output logic io_write_en,
    output scalar_t io_addr,
    output scalar_t io_write_value,

    output logic miss_en,
    output line_index_t miss_line_addr,
    output logic lru_update_en,
    output l1d_way_idx_t lru_update_way,

    output logic resp_valid,
    output logic resp_trap,
    output trap_cause_t resp_trap_cause,
    output logic resp_hit,
    output line_data_t load_data
);
    l1d_access_if access_bus();

    access_classifier classifier(
        .access(access_bus.classifier),
        .*);

    l1d_hit_data hit_data(
        .access(access_bus.lookup),
        .*);

    store_aligner aligner(
        .access(access_bus.aligner),
        .*);
endmodule

// ==== hw/l1d_access_if.sv ====
`include "l1d_defs.svh"

// Classified request as seen by the lookup and store units.
// All enables are already qualified by valid, TLB hit and no fault
interface l1d_access_if
    import l1d_geometry_pkg::*, mem_op_pkg::*;
();
    paddr_t paddr;
    mem_op_t op;
    line_data_t store_value;
    word_mask_t word_mask;
    logic cached_load_en;
    logic cached_store_en;

    // Cached load with a TLB hit, still set when the load faults
    logic lookup_en;

    modport classifier(output paddr, op, store_value, word_mask,
        cached_load_en, cached_store_en, lookup_en);

    modport lookup(input paddr, cached_load_en, cached_store_en, lookup_en);

    modport aligner(input paddr, op, store_value, word_mask, cached_store_en);
endinterface

// ==== hw/l1d_geometry_pkg.sv ====
`include "l1d_defs.svh"

package l1d_geometry_pkg;
    localparam int OFFSET_WIDTH = $clog2(`L1D_LINE_BYTES);
    localparam int SET_IDX_WIDTH = $clog2(`L1D_SETS);
    localparam int WAY_IDX_WIDTH = $clog2(`L1D_WAYS);
    localparam int TAG_WIDTH = `L1D_ADDR_WIDTH - SET_IDX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WORDS = `L1D_LINE_BYTES / 4;

    typedef logic [`L1D_ADDR_WIDTH - 1:0] paddr_t;
    typedef logic [TAG_WIDTH - 1:0] l1d_tag_t;
    typedef logic [SET_IDX_WIDTH - 1:0] l1d_set_idx_t;
    typedef logic [OFFSET_WIDTH - 1:0] line_offset_t;
    typedef logic [WAY_IDX_WIDTH - 1:0] l1d_way_idx_t;
    typedef logic [`L1D_ADDR_WIDTH - OFFSET_WIDTH - 1:0] line_index_t;
    typedef logic [`L1D_LINE_BYTES * 8 - 1:0] line_data_t;
    typedef logic [`L1D_LINE_BYTES - 1:0] byte_mask_t;
    typedef logic [LINE_WORDS - 1:0] word_mask_t;
    typedef logic [31:0] scalar_t;

    // Address is split as tag | set | offset, from the top bit down
    function automatic l1d_tag_t addr_tag(paddr_t addr);
        return addr[`L1D_ADDR_WIDTH - 1 -: TAG_WIDTH];
    endfunction

    function automatic l1d_set_idx_t addr_set(paddr_t addr);
        return addr[OFFSET_WIDTH +: SET_IDX_WIDTH];
    endfunction

    function automatic line_offset_t addr_offset(paddr_t addr);
        return addr[OFFSET_WIDTH - 1:0];
    endfunction

    function automatic line_index_t addr_line(paddr_t addr);
        return addr[`L1D_ADDR_WIDTH - 1:OFFSET_WIDTH];
    endfunction
endpackage

// ==== hw/l1d_hit_data.sv ====
`include "l1d_defs.svh"

module l1d_hit_data
    import l1d_geometry_pkg::*;
(
    input logic clk,
    input logic reset,

    l1d_access_if.lookup access,

    input logic fill_en,
    input l1d_way_idx_t fill_way,
    input l1d_set_idx_t fill_set,
    input l1d_tag_t fill_tag,
    input line_data_t fill_data,

    output logic miss_en,
    output line_index_t miss_line_addr,
    output logic lru_update_en,
    output l1d_way_idx_t lru_update_way,
    output logic resp_hit,
    output line_data_t load_data
);
    logic [`L1D_SETS - 1:0] way_valid[`L1D_WAYS];
    l1d_tag_t tag_array[`L1D_WAYS][`L1D_SETS];

    // One entry per way and set, addressed as {way, set}
    line_data_t data_array[`L1D_WAYS * `L1D_SETS];

    l1d_tag_t req_tag;
    l1d_set_idx_t req_set;
    logic [`L1D_WAYS - 1:0] way_hit_oh;
    l1d_way_idx_t hit_way;
    logic cache_hit;

    assign req_tag = addr_tag(access.paddr);
    assign req_set = addr_set(access.paddr);

    always_comb
    begin
        for (int way = 0; way < `L1D_WAYS; way++)
        begin
            way_hit_oh[way] = way_valid[way][req_set] && tag_array[way][req_set] == req_tag;
        end
    end

    // A line lives in at most one way, so OR-ing the indices encodes the hit
    always_comb
    begin
        hit_way = '0;
        for (int way = 0; way < `L1D_WAYS; way++)
        begin
            if (way_hit_oh[way])
                hit_way = hit_way | l1d_way_idx_t'(way);
        end
    end

    assign cache_hit = |way_hit_oh;

    assign miss_en = access.cached_load_en && !cache_hit;
    assign miss_line_addr = addr_line(access.paddr);
    assign lru_update_en = (access.cached_load_en || access.cached_store_en) && cache_hit;
    assign lru_update_way = hit_way;

    // Fills land at the clock edge, so lookups see them from the next cycle
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int way = 0; way < `L1D_WAYS; way++)
                way_valid[way] <= '0;
        end
        else if (fill_en)
            way_valid[fill_way][fill_set] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_array[fill_way][fill_set] <= fill_tag;
            data_array[{fill_way, fill_set}] <= fill_data;
        end
    end

    // The line is read even for a faulting load, only the hit flag is held back
    always_ff @(posedge clk)
    begin
        if (access.lookup_en && cache_hit)
            load_data <= data_array[{hit_way, req_set}];
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            resp_hit <= 1'b0;
        else
            resp_hit <= access.cached_load_en && cache_hit;
    end
endmodule

// ==== hw/mem_op_pkg.sv ====
`include "l1d_defs.svh"

package mem_op_pkg;
    // Access size. MEM_BLOCK moves a whole line, one word per lane
    typedef enum logic [1:0]
    {
        MEM_B,
        MEM_S,
        MEM_L,
        MEM_BLOCK
    } mem_op_t;

    // Listed in the order the faults are prioritized
    typedef enum logic [2:0]
    {
        TRAP_NONE,
        TRAP_TLB_MISS,
        TRAP_PAGE_FAULT,
        TRAP_SUPERVISOR,
        TRAP_UNALIGNED,
        TRAP_ILLEGAL_STORE
    } trap_cause_t;

    // True when the line offset does not suit the access size
    function automatic logic op_misaligned(mem_op_t op,
        logic [$clog2(`L1D_LINE_BYTES) - 1:0] offset);
        case (op)
            MEM_S: return offset[0];
            MEM_L: return |offset[1:0];
            MEM_BLOCK: return offset != '0;
            default: return 1'b0;
        endcase
    endfunction
endpackage

// ==== hw/store_aligner.sv ====
`include "l1d_defs.svh"

module store_aligner
    import l1d_geometry_pkg::*, mem_op_pkg::*;
(
    l1d_access_if.aligner access,

    output logic store_en,
    output line_index_t store_line_addr,
    output byte_mask_t store_mask,
    output line_data_t store_data
);
    line_offset_t offset;
    scalar_t scalar_value;
    word_mask_t lane_mask;
    logic [3:0] byte_sel;

    // Most significant byte goes to the lowest line offset
    function automatic scalar_t swap_bytes(scalar_t value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    assign offset = addr_offset(access.paddr);
    assign scalar_value = access.store_value[31:0];

    assign store_en = access.cached_store_en;
    assign store_line_addr = addr_line(access.paddr);

    // lane_mask picks words, byte_sel picks bytes inside each picked word
    always_comb
    begin
        lane_mask = '0;
        lane_mask[offset[OFFSET_WIDTH - 1:2]] = 1'b1;
        byte_sel = 4'b1111;
        case (access.op)
            MEM_B:
            begin
                byte_sel = 4'b0001 << offset[1:0];
                store_data = {`L1D_LINE_BYTES{scalar_value[7:0]}};
            end
            MEM_S:
            begin
                byte_sel = offset[1] ? 4'b1100 : 4'b0011;
                store_data = {LINE_WORDS * 2{scalar_value[7:0], scalar_value[15:8]}};
            end
            MEM_L:
                store_data = {LINE_WORDS{swap_bytes(scalar_value)}};
            default:
            begin
                // Block store, one value word per lane
                lane_mask = access.word_mask;
                for (int lane = 0; lane < LINE_WORDS; lane++)
                    store_data[lane * 32 +: 32] = swap_bytes(access.store_value[lane * 32 +: 32]);
            end
        endcase
    end

    always_comb
    begin
        for (int i = 0; i < `L1D_LINE_BYTES; i++)
            store_mask[i] = lane_mask[i / 4] & byte_sel[i % 4];
    end
endmodule

// ==== include/l1d_defs.svh ====
`ifndef L1D_DEFS_SVH
`define L1D_DEFS_SVH

// Number of ways in each set of the L1 data cache
`define L1D_WAYS 4

// Number of sets per way
`define L1D_SETS 64

// Size of one cache line in bytes
`define L1D_LINE_BYTES 64

// Width of a physical address
`define L1D_ADDR_WIDTH 32

// Upper half of every physical address in the I/O region.
// Accesses there bypass the cache
`define L1D_IO_PREFIX 16'hffff

`endif

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module dcache_data_stage_tb \
    -Mdir obj_dir

./obj_dir/Vdcache_data_stage_tb | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"

// ==== verification/dcache_data_stage_checker.sv ====
module dcache_data_stage_checker
(
    input logic clk,
    input logic reset,
    input logic store_en,
    input logic io_read_en,
    input logic io_write_en,
    input logic miss_en,
    input logic lru_update_en,
    input logic resp_trap
);
    // A request is either cached or uncached, never both
    store_io_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(store_en && (io_read_en || io_write_en)))
        else $error("store_en and an I/O enable were set in the same cycle");

    // A miss means no way matched, so there is no way to mark
    miss_lru_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(miss_en && lru_update_en))
        else $error("miss_en and lru_update_en were set in the same cycle");

    // A trapping request must not have left any side effect behind
    trap_without_side_effect: assert property (@(posedge clk) disable iff (reset)
        resp_trap |-> !$past(store_en || io_read_en || io_write_en))
        else $error("resp_trap follows a cycle with a store or I/O enable");
endmodule

// ==== verification/dcache_data_stage_tb.sv ====
`include "l1d_defs.svh"

module dcache_data_stage_tb
    import l1d_geometry_pkg::*, mem_op_pkg::*;
();
    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_MARGIN = 20;
    localparam logic [31:0] LFSR_SEED = 32'h78e19283;
    localparam logic [31:0] LFSR_TAPS = 32'ha3000000;

    // TLB bits in the order hit, present, supervisor, writable
    localparam logic [3:0] TLB_OK = 4'b1101;
    localparam logic [3:0] TLB_RO = 4'b1100;
    localparam logic [3:0] TLB_SUP = 4'b1111;

    localparam int FILL_COUNT = 6;
    localparam l1d_way_idx_t FILL_WAY[FILL_COUNT] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2};
    localparam l1d_set_idx_t FILL_SET[FILL_COUNT] = '{6'd5, 6'd5, 6'd5, 6'd9, 6'd33, 6'd63};
    localparam l1d_tag_t FILL_TAG[FILL_COUNT] =
        '{20'h12345, 20'h0abcd, 20'h00777, 20'h12345, 20'hfff00, 20'h55aa5};

    typedef struct packed
    {
        logic valid;
        mem_op_t op;
        logic load;
        paddr_t paddr;
        scalar_t value;
        word_mask_t lanes;
        logic [3:0] tlb;
        logic sup_en;
        trap_cause_t cause;
        byte_mask_t mask;
    } row_t;

    logic clk;
    logic reset;
    logic req_valid;
    mem_op_t req_op;
    logic req_load;
    paddr_t req_paddr;
    line_data_t req_store_value;
    word_mask_t req_word_mask;
    logic tlb_hit;
    logic tlb_present;
    logic tlb_supervisor;
    logic tlb_writable;
    logic supervisor_en;
    logic fill_en;
    l1d_way_idx_t fill_way;
    l1d_set_idx_t fill_set;
    l1d_tag_t fill_tag;
    line_data_t fill_data;
    logic store_en;
    line_index_t store_line_addr;
    byte_mask_t store_mask;
    line_data_t store_data;
    logic io_read_en;
    logic io_write_en;
    scalar_t io_addr;
    scalar_t io_write_value;
    logic miss_en;
    line_index_t miss_line_addr;
    logic lru_update_en;
    l1d_way_idx_t lru_update_way;
    logic resp_valid;
    logic resp_trap;
    trap_cause_t resp_trap_cause;
    logic resp_hit;
    line_data_t load_data;

    row_t rows[$];
    row_t cur_row;
    line_data_t model_line[FILL_COUNT];
    logic [31:0] lfsr_state;
    logic table_built;
    int check_count;
    int error_count;

    // Expected values of the row in the request cycle
    logic exp_store_en;
    logic exp_io_read_en;
    logic exp_io_write_en;
    logic exp_miss_en;
    logic exp_lru_en;
    int exp_line;

    // Expected response of the row now in the response register
    logic pend_valid;
    trap_cause_t pend_cause;
    logic pend_hit;
    int pend_line;

    dcache_data_stage i_dut (.*);

    bind dcache_data_stage dcache_data_stage_checker protocol_checks
    (
        .clk(clk),
        .reset(reset),
        .store_en(store_en),
        .io_read_en(io_read_en),
        .io_write_en(io_write_en),
        .miss_en(miss_en),
        .lru_update_en(lru_update_en),
        .resp_trap(resp_trap)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic take_random_bit();
        logic bit_out;
        bit_out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (bit_out)
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        return bit_out;
    endfunction

    function automatic line_data_t random_line();
        line_data_t line;
        for (int i = 0; i < 512; i++)
            line[i] = take_random_bit();
        return line;
    endfunction

    function automatic paddr_t make_addr(l1d_tag_t tag, l1d_set_idx_t set_idx,
        line_offset_t offset);
        return {tag, set_idx, offset};
    endfunction

    // Word 0 carries the scalar, the other words differ so stray lanes show up
    function automatic line_data_t value_line(scalar_t value);
        line_data_t line;
        for (int j = 0; j < 16; j++)
            line[j * 32 +: 32] = value ^ (32'h11111111 * j);
        return line;
    endfunction

    // Big-endian placement with byte i of the line at data bits 8i
    function automatic line_data_t expected_store_data(mem_op_t op, line_data_t values);
        line_data_t line;
        scalar_t word;
        for (int i = 0; i < 64; i++)
        begin
            word = (op == MEM_BLOCK) ? values[(i / 4) * 32 +: 32] : values[31:0];
            case (op)
                MEM_B: line[i * 8 +: 8] = word[7:0];
                MEM_S: line[i * 8 +: 8] = (i % 2 == 0) ? word[15:8] : word[7:0];
                default: line[i * 8 +: 8] = word[31 - (i % 4) * 8 -: 8];
            endcase
        end
        return line;
    endfunction

    // Index of the filled line holding this address, or -1 on a miss
    function automatic int find_line(paddr_t addr);
        int found;
        found = -1;
        for (int f = 0; f < FILL_COUNT; f++)
        begin
            if (FILL_TAG[f] == addr[31:12] && FILL_SET[f] == addr[11:6])
                found = f;
        end
        return found;
    endfunction

    task automatic check_value(string name, logic [511:0] actual, logic [511:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic add_row(logic valid, mem_op_t op, logic load, paddr_t paddr,
        scalar_t value, word_mask_t lanes, logic [3:0] tlb, logic sup_en,
        trap_cause_t cause, byte_mask_t mask);
        rows.push_back({valid, op, load, paddr, value, lanes, tlb, sup_en, cause, mask});
    endtask

    task automatic build_table();
        // Load hits in every filled way, then misses and an idle cycle
        add_row(1, MEM_L, 1, make_addr(20'h12345, 5, 0), 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_L, 1, make_addr(20'h0abcd, 5, 4), 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_B, 1, make_addr(20'h00777, 5, 3), 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_S, 1, make_addr(20'h12345, 9, 2), 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_BLOCK, 1, make_addr(20'hfff00, 33, 0), 0, 16'hffff, TLB_OK, 0,
            TRAP_NONE, 0);
        add_row(1, MEM_L, 1, make_addr(20'h55aa5, 63, 60), 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_L, 1, make_addr(20'h12346, 5, 8), 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_B, 1, make_addr(20'h12345, 6, 1), 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(0, MEM_L, 1, make_addr(20'h12345, 5, 0), 0, 0, TLB_OK, 0, TRAP_NONE, 0);

        // Stores of every size, the first and fifth of them to filled lines
        add_row(1, MEM_B, 0, make_addr(20'h12345, 5, 5), 32'hdeadbeef, 0, TLB_OK, 0,
            TRAP_NONE, 64'h20);
        add_row(1, MEM_B, 0, make_addr(20'h00000, 0, 63), 32'h000000a5, 0, TLB_OK, 0,
            TRAP_NONE, 64'h8000_0000_0000_0000);
        add_row(1, MEM_S, 0, make_addr(20'h00001, 2, 6), 32'h1234abcd, 0, TLB_OK, 0,
            TRAP_NONE, 64'hc0);
        add_row(1, MEM_S, 0, make_addr(20'h00001, 2, 62), 32'h1234abcd, 0, TLB_OK, 0,
            TRAP_NONE, 64'hc000_0000_0000_0000);
        add_row(1, MEM_L, 0, make_addr(20'h0abcd, 5, 8), 32'hcafef00d, 0, TLB_OK, 0,
            TRAP_NONE, 64'hf00);
        add_row(1, MEM_L, 0, make_addr(20'h00002, 3, 60), 32'h01020304, 0, TLB_OK, 0,
            TRAP_NONE, 64'hf000_0000_0000_0000);
        add_row(1, MEM_BLOCK, 0, make_addr(20'h00003, 4, 0), 32'h0badc0de, 16'hffff, TLB_OK, 0,
            TRAP_NONE, 64'hffff_ffff_ffff_ffff);
        add_row(1, MEM_BLOCK, 0, make_addr(20'h00003, 4, 0), 32'h76543210, 16'h0005, TLB_OK, 0,
            TRAP_NONE, 64'h0f0f);
        add_row(1, MEM_BLOCK, 0, make_addr(20'h00003, 4, 0), 32'h89abcdef, 16'h8001, TLB_OK, 0,
            TRAP_NONE, 64'hf000_0000_0000_000f);
        add_row(1, MEM_BLOCK, 0, make_addr(20'h00003, 4, 0), 32'h13579bdf, 16'h0240, TLB_OK, 0,
            TRAP_NONE, 64'h0000_00f0_0f00_0000);

        // I/O region, and an address just below it that stays cached
        add_row(1, MEM_L, 1, 32'hffff_1230, 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_L, 0, 32'hffff_0104, 32'h89abcdef, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_B, 1, 32'hffff_ffff, 0, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_S, 0, 32'hffff_0002, 32'h0000beef, 0, TLB_OK, 0, TRAP_NONE, 0);
        add_row(1, MEM_L, 1, 32'hfffe_0040, 0, 0, TLB_OK, 0, TRAP_NONE, 0);

        // Faults alone and combined, the highest priority wins
        add_row(1, MEM_L, 1, make_addr(20'h12345, 5, 0), 0, 0, 4'b0101, 0, TRAP_TLB_MISS, 0);
        add_row(1, MEM_S, 0, make_addr(20'h00001, 2, 1), 0, 0, 4'b0000, 0, TRAP_TLB_MISS, 0);
        add_row(1, MEM_L, 1, make_addr(20'h12345, 5, 0), 0, 0, 4'b1001, 0, TRAP_PAGE_FAULT, 0);
        add_row(1, MEM_L, 0, make_addr(20'h00001, 2, 4), 0, 0, 4'b1000, 0, TRAP_PAGE_FAULT, 0);
        add_row(1, MEM_L, 1, make_addr(20'h12345, 5, 0), 0, 0, TLB_SUP, 0, TRAP_SUPERVISOR, 0);
        add_row(1, MEM_L, 1, make_addr(20'h12345, 5, 0), 0, 0, TLB_SUP, 1, TRAP_NONE, 0);
        add_row(1, MEM_L, 0, make_addr(20'h00001, 2, 2), 0, 0, 4'b1110, 0, TRAP_SUPERVISOR, 0);
        add_row(1, MEM_L, 1, make_addr(20'h12345, 5, 2), 0, 0, TLB_OK, 0, TRAP_UNALIGNED, 0);
        add_row(1, MEM_S, 0, make_addr(20'h00001, 2, 1), 0, 0, TLB_RO, 0, TRAP_UNALIGNED, 0);
        add_row(1, MEM_BLOCK, 1, make_addr(20'hfff00, 33, 4), 0, 16'hffff, TLB_OK, 0,
            TRAP_UNALIGNED, 0);
        add_row(1, MEM_L, 0, make_addr(20'h00001, 2, 4), 0, 0, TLB_RO, 0, TRAP_ILLEGAL_STORE, 0);
        add_row(1, MEM_L, 0, 32'hffff_0010, 0, 0, TLB_RO, 0, TRAP_ILLEGAL_STORE, 0);
        add_row(1, MEM_S, 1, 32'hffff_0011, 0, 0, TLB_OK, 0, TRAP_UNALIGNED, 0);
        add_row(1, MEM_B, 0, make_addr(20'h00001, 2, 3), 0, 0, 4'b1110, 1, TRAP_ILLEGAL_STORE, 0);
        add_row(1, MEM_L, 1, 32'hffff_0020, 0, 0, 4'b0111, 0, TRAP_TLB_MISS, 0);
    endtask

    task automatic apply_row(row_t row);
        logic cached;
        logic ok;
        cur_row = row;
        req_valid = row.valid;
        req_op = row.op;
        req_load = row.load;
        req_paddr = row.paddr;
        req_store_value = value_line(row.value);
        req_word_mask = row.lanes;
        {tlb_hit, tlb_present, tlb_supervisor, tlb_writable} = row.tlb;
        supervisor_en = row.sup_en;

        cached = row.paddr[31:16] != `L1D_IO_PREFIX;
        ok = row.valid && row.cause == TRAP_NONE;
        exp_line = find_line(row.paddr);
        exp_store_en = ok && cached && !row.load;
        exp_io_read_en = ok && !cached && row.load;
        exp_io_write_en = ok && !cached && !row.load;
        exp_miss_en = ok && cached && row.load && exp_line < 0;
        exp_lru_en = ok && cached && exp_line >= 0;

        pend_valid = row.valid;
        pend_cause = row.cause;
        pend_hit = ok && cached && row.load && exp_line >= 0;
        pend_line = exp_line;
    endtask

    task automatic check_request_outputs();
        check_value("store_en", 512'(store_en), 512'(exp_store_en));
        check_value("io_read_en", 512'(io_read_en), 512'(exp_io_read_en));
        check_value("io_write_en", 512'(io_write_en), 512'(exp_io_write_en));
        check_value("miss_en", 512'(miss_en), 512'(exp_miss_en));
        check_value("lru_update_en", 512'(lru_update_en), 512'(exp_lru_en));
        if (exp_store_en)
        begin
            check_value("store_line_addr", 512'(store_line_addr), 512'(cur_row.paddr[31:6]));
            check_value("store_mask", 512'(store_mask), 512'(cur_row.mask));
            check_value("store_data", store_data,
                expected_store_data(cur_row.op, value_line(cur_row.value)));
        end
        if (exp_io_read_en || exp_io_write_en)
            check_value("io_addr", 512'(io_addr), 512'({16'd0, cur_row.paddr[15:0]}));
        if (exp_io_write_en)
            check_value("io_write_value", 512'(io_write_value), 512'(cur_row.value));
        if (exp_miss_en)
            check_value("miss_line_addr", 512'(miss_line_addr), 512'(cur_row.paddr[31:6]));
        if (exp_lru_en)
            check_value("lru_update_way", 512'(lru_update_way), 512'(FILL_WAY[exp_line]));
    endtask

    task automatic check_response();
        check_value("resp_valid", 512'(resp_valid), 512'(pend_valid));
        check_value("resp_trap", 512'(resp_trap), 512'(pend_valid && pend_cause != TRAP_NONE));
        check_value("resp_trap_cause", 512'(resp_trap_cause), 512'(pend_cause));
        check_value("resp_hit", 512'(resp_hit), 512'(pend_hit));
        if (pend_hit)
            check_value("load_data", load_data, model_line[pend_line]);
    endtask

    initial
    begin
        table_built = 1'b0;
        check_count = 0;
        error_count = 0;
        lfsr_state = LFSR_SEED;
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = MEM_B;
        req_load = 1'b0;
        req_paddr = '0;
        req_store_value = '0;
        req_word_mask = '0;
        {tlb_hit, tlb_present, tlb_supervisor, tlb_writable} = 4'b0000;
        supervisor_en = 1'b0;
        fill_en = 1'b0;
        fill_way = '0;
        fill_set = '0;
        fill_tag = '0;
        fill_data = '0;
        build_table();
        table_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int f = 0; f < FILL_COUNT; f++)
        begin
            @(negedge clk);
            model_line[f] = random_line();
            fill_en = 1'b1;
            fill_way = FILL_WAY[f];
            fill_set = FILL_SET[f];
            fill_tag = FILL_TAG[f];
            fill_data = model_line[f];
        end
        @(negedge clk);
        fill_en = 1'b0;

        // The response of each row is checked while the next row is driven
        for (int r = 0; r <= rows.size(); r++)
        begin
            @(negedge clk);
            if (r > 0)
                check_response();
            if (r < rows.size())
            begin
                apply_row(rows[r]);
                #(CLK_PERIOD / 2 - 1);
                check_request_outputs();
            end
            else
                req_valid = 1'b0;
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        wait (table_built);
        #((rows.size() + RESET_CYCLES + FILL_COUNT + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("Watchdog timeout: the run did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end
endmodule

// ==== verilog.f ====
+incdir+include
hw/l1d_geometry_pkg.sv
hw/mem_op_pkg.sv
hw/l1d_access_if.sv
hw/access_classifier.sv
hw/l1d_hit_data.sv
hw/store_aligner.sv
hw/dcache_data_stage.sv
verification/dcache_data_stage_checker.sv
verification/dcache_data_stage_tb.sv
